// ==== hw/fetch_predict_pkg.sv ====
package fetch_predict_pkg;

    // Address geometry.
    localparam int ADDR_BITS = 32;
    localparam int OFFSET_BITS = 2;
    localparam int INSTR_BYTES = 4;

    // Default set-index width, overridden per instance through INDEX_BITS.
    localparam int INDEX_BITS_DEFAULT = 10;

    // Tag always sits above the default index, whatever the array depth.
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS_DEFAULT - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // First fetch address after reset.
    localparam addr_t RESET_PC = 32'h0000_1000;

    // Prediction returned by the BTB one cycle after a lookup.
    typedef struct packed {
        logic  hit;
        addr_t target;
        logic  way;
    } pred_t;

    // One executed branch, with the prediction that travelled along with it.
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
        pred_t pred;
    } resolve_t;

    // BTB write or invalidate command from the resolution unit.
    typedef struct packed {
        logic  write;
        logic  invalidate;
        addr_t pc;
        addr_t target;
        logic  way_hint;
        // Hinted way holds this branch and gets overwritten, not filled.
        logic  hinted;
    } btb_update_t;

    // Fetch PC generator states.
    typedef enum logic {
        FETCH_RESET,
        FETCH_RUN
    } fetch_state_t;

    // Tag field of an instruction address.
    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

endpackage

// ==== hw/btb_set_array.sv ====
module btb_set_array #(
    parameter int INDEX_BITS = fetch_predict_pkg::INDEX_BITS_DEFAULT
) (
    input  logic                             CLK,
    input  logic                             reset,
    input  logic [INDEX_BITS-1:0]            rd_index,
    output logic [1:0]                       rd_valid,
    output fetch_predict_pkg::tag_t [1:0]    rd_tag,
    output fetch_predict_pkg::addr_t [1:0]   rd_target,
    output logic                             rd_lru,
    input  logic                             wr_en,
    input  logic [INDEX_BITS-1:0]            wr_index,
    input  logic                             wr_way,
    input  logic                             wr_valid,
    input  fetch_predict_pkg::tag_t          wr_tag,
    input  fetch_predict_pkg::addr_t         wr_target,
    input  logic                             lru_en,
    input  logic [INDEX_BITS-1:0]            lru_index,
    input  logic                             lru_value
);
    import fetch_predict_pkg::*;

    localparam int DEPTH = 1 << INDEX_BITS;

    // Payload storage per way.
    tag_t  tag_mem    [0:1][0:DEPTH-1];
    addr_t target_mem [0:1][0:DEPTH-1];

    // Valid bit per way and set, LRU way per set.
    logic [1:0][DEPTH-1:0] valid_q;
    logic [DEPTH-1:0]      lru_q;

    // Asynchronous read of both ways.
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd_valid[w]  = valid_q[w][rd_index];
            rd_tag[w]    = tag_mem[w][rd_index];
            rd_target[w] = target_mem[w][rd_index];
        end
        rd_lru = lru_q[rd_index];
    end

    // Tag and target only change on a real fill.
    always_ff @(posedge CLK) begin
        if (wr_en && wr_valid) begin
            tag_mem[wr_way][wr_index]    <= wr_tag;
            target_mem[wr_way][wr_index] <= wr_target;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (lru_en) begin
                lru_q[lru_index] <= lru_value;
            end
            if (wr_en) begin
                valid_q[wr_way][wr_index] <= wr_valid;
                // A fill makes the written way most recent.
                // Placed last so it beats a touch of the same set.
                if (wr_valid) begin
                    lru_q[wr_index] <= ~wr_way;
                end
            end
        end
    end

    // Filled entries always point somewhere real.
    a_fill_target_nonzero: assert property (
        @(posedge CLK) disable iff (reset)
        (wr_en && wr_valid) |-> (wr_target != '0)
    );

endmodule

// ==== hw/btb.sv ====
module btb #(
    parameter int INDEX_BITS = fetch_predict_pkg::INDEX_BITS_DEFAULT
) (
    input  logic                           CLK,
    input  logic                           reset,
    input  fetch_predict_pkg::addr_t       lookup_pc,
    input  logic                           lookup_en,
    input  fetch_predict_pkg::btb_update_t update,
    output fetch_predict_pkg::pred_t       prediction
);
    import fetch_predict_pkg::*;

    typedef logic [INDEX_BITS-1:0] index_t;

    // Lookup side.
    index_t      lk_index;
    tag_t        lk_tag;
    logic [1:0]  lk_valid;
    tag_t [1:0]  lk_tags;
    addr_t [1:0] lk_targets;
    logic [1:0]  lk_match;
    logic        lk_hit;
    logic        lk_way;
    pred_t       pred_next;

    // Update side.
    index_t      up_index;
    tag_t        up_tag;
    logic [1:0]  up_valid;
    tag_t [1:0]  up_tags;
    logic        up_lru;
    logic [1:0]  up_match;
    logic        up_present;
    logic        up_active;
    logic        hint_ok;
    logic        match_way;
    logic        fill_way;

    // Array write commands.
    logic        wr_en;
    logic        wr_way;
    logic        lru_en;

    assign lk_index = lookup_pc[OFFSET_BITS +: INDEX_BITS];
    assign lk_tag   = addr_tag(lookup_pc);
    assign up_index = update.pc[OFFSET_BITS +: INDEX_BITS];
    assign up_tag   = addr_tag(update.pc);

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            lk_match[w] = lk_valid[w] && (lk_tags[w] == lk_tag);
            up_match[w] = up_valid[w] && (up_tags[w] == up_tag);
        end
    end

    assign lk_hit = lookup_en && (|lk_match);
    assign lk_way = lk_match[1];

    always_comb begin
        pred_next.hit    = lk_hit;
        pred_next.way    = lk_hit ? lk_way : 1'b0;
        pred_next.target = lk_hit ? lk_targets[lk_way] : '0;
    end

    // Trust the hint only while that way still holds the branch.
    assign hint_ok    = update.hinted && up_match[update.way_hint];
    assign match_way  = hint_ok ? update.way_hint : up_match[1];
    assign up_present = |up_match;
    assign up_active  = update.write || update.invalidate;

    // Invalid way first, then the LRU way.
    assign fill_way = !up_valid[0] ? 1'b0 :
                      !up_valid[1] ? 1'b1 : up_lru;

    assign wr_way = up_present ? match_way : fill_way;
    assign wr_en  = update.write || (update.invalidate && up_present);

    // Same-set update owns the LRU bit this edge.
    assign lru_en = lk_hit && !(up_active && (up_index == lk_index));

    // Two mirrored copies give lookup and update their own read port.
    btb_set_array #(.INDEX_BITS(INDEX_BITS)) u_lookup_bank (
        .CLK       (CLK),
        .reset     (reset),
        .rd_index  (lk_index),
        .rd_valid  (lk_valid),
        .rd_tag    (lk_tags),
        .rd_target (lk_targets),
        .rd_lru    (),
        .wr_en     (wr_en),
        .wr_index  (up_index),
        .wr_way    (wr_way),
        .wr_valid  (update.write),
        .wr_tag    (up_tag),
        .wr_target (update.target),
        .lru_en    (lru_en),
        .lru_index (lk_index),
        .lru_value (~lk_way)
    );

    btb_set_array #(.INDEX_BITS(INDEX_BITS)) u_update_bank (
        .CLK       (CLK),
        .reset     (reset),
        .rd_index  (up_index),
        .rd_valid  (up_valid),
        .rd_tag    (up_tags),
        .rd_target (),
        .rd_lru    (up_lru),
        .wr_en     (wr_en),
        .wr_index  (up_index),
        .wr_way    (wr_way),
        .wr_valid  (update.write),
        .wr_tag    (up_tag),
        .wr_target (update.target),
        .lru_en    (lru_en),
        .lru_index (lk_index),
        .lru_value (~lk_way)
    );

    always_ff @(posedge CLK) begin
        if (reset) begin
            prediction <= '0;
        end else begin
            prediction <= pred_next;
        end
    end

    // A set never holds one branch twice.
    a_no_duplicate_tag: assert property (
        @(posedge CLK) disable iff (reset)
        !((lk_valid == 2'b11) && (lk_tags[0] == lk_tags[1]))
    );

endmodule

// ==== hw/branch_resolve.sv ====
module branch_resolve (
    input  fetch_predict_pkg::resolve_t    resolve,
    output logic                           redirect,
    output fetch_predict_pkg::addr_t       redirect_target,
    output fetch_predict_pkg::btb_update_t update
);
    import fetch_predict_pkg::*;

    logic  pred_hit;
    logic  wrong_target;
    logic  taken_miss;
    logic  not_taken_hit;
    logic  mispredict;
    addr_t fall_through;

    assign pred_hit     = resolve.pred.hit;
    assign fall_through = resolve.pc + addr_t'(INSTR_BYTES);

    // Predicted taken, but to the wrong place.
    assign wrong_target = pred_hit && (resolve.pred.target != resolve.target);

    // Taken with no prediction at all, or with a stale target.
    assign taken_miss = resolve.taken && (!pred_hit || wrong_target);

    // Predicted taken, fell through.
    assign not_taken_hit = !resolve.taken && pred_hit;

    assign mispredict = taken_miss || not_taken_hit;

    assign redirect        = resolve.valid && mispredict;
    assign redirect_target = resolve.taken ? resolve.target : fall_through;

    always_comb begin
        update.write      = resolve.valid && taken_miss;
        update.invalidate = resolve.valid && not_taken_hit;
        update.pc         = resolve.pc;
        update.target     = resolve.target;
        // The predicting way is the one to overwrite or drop.
        update.way_hint   = resolve.pred.way;
        update.hinted     = pred_hit;
    end

endmodule

// ==== hw/fetch_pc.sv ====
module fetch_pc (
    input  logic                     CLK,
    input  logic                     reset,
    input  fetch_predict_pkg::pred_t prediction,
    input  logic                     redirect,
    input  fetch_predict_pkg::addr_t redirect_target,
    output fetch_predict_pkg::addr_t pc
);
    import fetch_predict_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_next;
    addr_t        pc_q;
    addr_t        pc_next;

    always_comb begin
        case (state_q)
            FETCH_RESET: state_next = FETCH_RUN;
            FETCH_RUN:   state_next = FETCH_RUN;
            default:     state_next = FETCH_RESET;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state_q <= FETCH_RESET;
        end else begin
            state_q <= state_next;
        end
    end

    // Boot address shows until the machine starts running.
    assign pc = (state_q == FETCH_RESET) ? RESET_PC : pc_q;

    // Redirect beats prediction beats sequential.
    always_comb begin
        if (redirect) begin
            pc_next = redirect_target;
        end else if (prediction.hit) begin
            pc_next = prediction.target;
        end else begin
            pc_next = pc + addr_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge CLK) begin
        pc_q <= pc_next;
    end

    // Redirect and BTB targets must both keep fetch word aligned.
    a_pc_aligned: assert property (
        @(posedge CLK) disable iff (reset)
        pc[OFFSET_BITS-1:0] == '0
    );

endmodule

// ==== hw/fetch_predict_top.sv ====
module fetch_predict_top #(
    parameter int INDEX_BITS = fetch_predict_pkg::INDEX_BITS_DEFAULT
) (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic                        is_branch,
    input  fetch_predict_pkg::resolve_t resolve,
    output fetch_predict_pkg::addr_t    fetch_pc,
    output fetch_predict_pkg::pred_t    prediction,
    output logic                        redirect
);
    import fetch_predict_pkg::*;

    addr_t       redirect_target;
    btb_update_t update;

    fetch_pc u_fetch_pc (
        .CLK             (CLK),
        .reset           (reset),
        .prediction      (prediction),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (fetch_pc)
    );

    btb #(.INDEX_BITS(INDEX_BITS)) u_btb (
        .CLK        (CLK),
        .reset      (reset),
        .lookup_pc  (fetch_pc),
        .lookup_en  (is_branch),
        .update     (update),
        .prediction (prediction)
    );

    branch_resolve u_branch_resolve (
        .resolve         (resolve),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .update          (update)
    );

endmodule

// ==== test/btb_ref_model.svh ====
`ifndef BTB_REF_MODEL_SVH
`define BTB_REF_MODEL_SVH

// Reference model of the sets, LRU bits, prediction register and fetch PC.
// Uses INDEX_BITS and the package import of the including module.

localparam int M_SETS = 1 << INDEX_BITS;

logic  m_valid  [0:1][0:M_SETS-1];
tag_t  m_tag    [0:1][0:M_SETS-1];
addr_t m_target [0:1][0:M_SETS-1];
logic  m_lru    [0:M_SETS-1];
addr_t m_pc;
pred_t m_pred;

function automatic int set_of(addr_t a);
    return int'(a[OFFSET_BITS +: INDEX_BITS]);
endfunction

// Upper address bits, above the default index width.
function automatic tag_t tag_of(addr_t a);
    return a[ADDR_BITS-1 -: TAG_BITS];
endfunction

// Way that holds this branch, or -1.
function automatic int find_way(addr_t a);
    for (int w = 0; w < 2; w++) begin
        if (m_valid[w][set_of(a)] && (m_tag[w][set_of(a)] == tag_of(a))) return w;
    end
    return -1;
endfunction

function automatic logic is_mispredict(resolve_t r);
    if (r.taken) return !r.pred.hit || (r.pred.target != r.target);
    return r.pred.hit;
endfunction

function automatic addr_t redirect_dest(resolve_t r);
    return r.taken ? r.target : r.pc + 32'd4;
endfunction

task automatic reset_model();
    for (int s = 0; s < M_SETS; s++) begin
        m_valid[0][s] = 1'b0;
        m_valid[1][s] = 1'b0;
        m_lru[s] = 1'b0;
    end
    m_pc = RESET_PC;
    m_pred = '0;
endtask

// One clock edge, with the inputs that the DUT samples at it.
task automatic advance_model(logic lookup_en, resolve_t r);
    pred_t next_pred;
    int    lk_set;
    int    lk_way;
    int    up_set;
    int    up_way;
    logic  mispredict;
    next_pred = '0;
    lk_set = set_of(m_pc);
    lk_way = find_way(m_pc);
    if (lookup_en && (lk_way >= 0)) begin
        next_pred.hit = 1'b1;
        next_pred.way = lk_way[0];
        next_pred.target = m_target[lk_way][lk_set];
    end
    mispredict = r.valid && is_mispredict(r);
    // Redirect first, then the prediction, then sequential.
    if (mispredict) m_pc = redirect_dest(r);
    else if (m_pred.hit) m_pc = m_pred.target;
    else m_pc = m_pc + 32'd4;
    m_pred = next_pred;
    up_set = set_of(r.pc);
    up_way = find_way(r.pc);
    if (mispredict && r.taken) begin
        // New branch takes an invalid way first, else the LRU way.
        if (up_way < 0) begin
            if (!m_valid[0][up_set]) up_way = 0;
            else if (!m_valid[1][up_set]) up_way = 1;
            else up_way = int'(m_lru[up_set]);
        end
        m_valid[up_way][up_set] = 1'b1;
        m_tag[up_way][up_set] = tag_of(r.pc);
        m_target[up_way][up_set] = r.target;
        m_lru[up_set] = (up_way == 0);
    end else if (mispredict && (up_way >= 0)) begin
        m_valid[up_way][up_set] = 1'b0;
    end
    // An update to the same set drops the lookup's LRU touch
    if (next_pred.hit && !(mispredict && (up_set == lk_set))) m_lru[lk_set] = !next_pred.way;
endtask

`endif

// ==== test/fetch_predict_tb.sv ====
module fetch_predict_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_predict_pkg::*;

    localparam int  INDEX_BITS    = 4;
    localparam int  POOL_SIZE     = 24;
    localparam int  RANDOM_CYCLES = 2900;
    localparam int  TOTAL_CYCLES  = 3000;
    localparam time CLK_PERIOD    = 4ns;
    // Whole run plus some slack.
    localparam time WATCHDOG      = TOTAL_CYCLES * CLK_PERIOD + 200ns;

    logic     CLK;
    logic     reset;
    logic     is_branch;
    resolve_t resolve;
    addr_t    fetch_pc;
    pred_t    prediction;
    logic     redirect;

    integer   seed = 32'h7ebf_94f3;
    int       errors = 0;
    int       checks = 0;
    logic     model_ready = 1'b0;
    logic     seen_taken = 1'b0;
    logic     last_lookup_en = 1'b0;
    addr_t    last_lookup_pc;
    addr_t    pool [POOL_SIZE];
    pred_t    captured [addr_t];

    `include "btb_ref_model.svh"

    fetch_predict_top #(.INDEX_BITS(INDEX_BITS)) dut (
        .CLK        (CLK),
        .reset      (reset),
        .is_branch  (is_branch),
        .resolve    (resolve),
        .fetch_pc   (fetch_pc),
        .prediction (prediction),
        .redirect   (redirect)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic check_equal(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Model steps with the inputs sampled at each edge.
    always @(posedge CLK) begin
        if (reset) begin
            reset_model();
            model_ready = 1'b1;
        end else if (model_ready) begin
            if (resolve.valid && resolve.taken) seen_taken = 1'b1;
            advance_model(is_branch, resolve);
        end
    end

    // Outputs are settled at the falling edge.
    always @(negedge CLK) begin
        if (model_ready) begin
            check_equal("fetch_pc", fetch_pc, m_pc);
            check_equal("prediction", prediction, m_pred);
            check_equal("redirect", redirect, resolve.valid && is_mispredict(resolve));
            if (!seen_taken) check_equal("hit before first fill", prediction.hit, 1'b0);
            // Remember what the BTB said about each looked-up address.
            if (last_lookup_en) captured[last_lookup_pc] = prediction;
            last_lookup_en = is_branch;
            last_lookup_pc = fetch_pc;
        end
    end

    // One cycle of stimulus, launched at the rising edge.
    task automatic drive(logic branch, logic valid, addr_t pc, logic taken, addr_t target,
                         logic follow_pred);
        resolve_t r;
        @(posedge CLK);
        r = '0;
        r.valid = valid;
        r.pc = pc;
        r.taken = taken;
        r.target = target;
        if (captured.exists(pc)) r.pred = captured[pc];
        if (follow_pred && taken && r.pred.hit) r.target = r.pred.target;
        is_branch <= branch;
        resolve   <= r;
    endtask

    // Taken branch at via, never looked up, so fetch jumps to dest.
    task automatic redirect_to(addr_t via, addr_t dest);
        drive(1'b0, 1'b1, via, 1'b1, dest, 1'b0);
    endtask

    task automatic expect_lookup(addr_t a, logic hit, addr_t target);
        drive(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge CLK);
        check_equal("directed fetch_pc", fetch_pc, a);
        drive(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge CLK);
        check_equal("directed hit", prediction.hit, hit);
        check_equal("directed target", prediction.target, hit ? target : '0);
    endtask

    task automatic random_cycle();
        logic  valid;
        logic  taken;
        logic  branch;
        addr_t pc;
        addr_t target;
        valid  = ($random(seed) & 7) < 3;
        taken  = ($random(seed) & 3) != 0;
        branch = $random(seed) & 1;
        pc     = pool[$unsigned($random(seed)) % POOL_SIZE];
        target = pool[$unsigned($random(seed)) % POOL_SIZE];
        drive(branch, valid, pc, taken, target, $random(seed) & 1);
    endtask

    initial begin
        reset = 1'b1;
        is_branch = 1'b0;
        resolve = '0;
        // Tags 1 to 4 at random sets, bits between index and tag kept zero.
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = (addr_t'(1 + i % 4) << (ADDR_BITS - TAG_BITS))
                    | (addr_t'($unsigned($random(seed)) % M_SETS) << OFFSET_BITS);
        end
        repeat (3) @(posedge CLK);
        reset <= 1'b0;

        // Lookups on the empty BTB.
        repeat (4) drive(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);

        // Fill, hit, invalidate, miss.
        redirect_to(32'h0000_3014, 32'h0000_3014);
        expect_lookup(32'h0000_3014, 1'b1, 32'h0000_3014);
        drive(1'b0, 1'b1, 32'h0000_3014, 1'b0, 32'h0000_3014, 1'b0);
        redirect_to(32'h0000_301C, 32'h0000_3014);
        expect_lookup(32'h0000_3014, 1'b0, '0);

        // Three tags in set 9.
        redirect_to(32'h0000_1024, 32'h0000_4000);
        redirect_to(32'h0000_2024, 32'h0000_4000);
        redirect_to(32'h0000_4008, 32'h0000_1024);
        expect_lookup(32'h0000_1024, 1'b1, 32'h0000_4000);
        // The hit leaves the second tag as LRU, so the third replaces it.
        redirect_to(32'h0000_3024, 32'h0000_4000);
        redirect_to(32'h0000_400C, 32'h0000_2024);
        expect_lookup(32'h0000_2024, 1'b0, '0);
        redirect_to(32'h0000_400C, 32'h0000_1024);
        expect_lookup(32'h0000_1024, 1'b1, 32'h0000_4000);

        for (int n = 0; n < RANDOM_CYCLES; n++) random_cycle();
        drive(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge CLK);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout after %0t, the run did not reach its end", WATCHDOG);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== fetch_predict_top.f ====
+incdir+test
hw/fetch_predict_pkg.sv
hw/btb_set_array.sv
hw/btb.sv
hw/branch_resolve.sv
hw/fetch_pc.sv
hw/fetch_predict_top.sv
test/fetch_predict_tb.sv
